/* Makefile */
BIN  := obj_dir/Vdecode_stage_tb
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -qx 'Simulation passed'

$(BIN): sim.f $(SRCS)
	verilator --binary --assert --top-module decode_stage_tb -f sim.f

clean:
	rm -rf obj_dir

/* dv/decode_stage_asserts.sv */
// Decode stage assertions
`timescale 1ns/1ps

module decode_stage_asserts (
    input logic                clk,
    input logic                rst,
    input logic                stall,
    input mips_pkg::phase_t    phase,
    input mips_pkg::instcode_t instr_code,
    input logic [4:0]          dest_reg,
    input logic [4:0]          shift_amount,
    input logic [25:0]         jump_target,
    input logic [31:0]         operand_a,
    input logic [31:0]         operand_b,
    input logic                reg_write_en,
    input logic                out_valid
);

    int fail_count = 0;   // read by the testbench summary

    // EXEC2 lasts a single cycle unless stalled
    assert property (@(posedge clk) disable iff (rst) out_valid && !stall |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in two unstalled cycles");
        end

    assert property (@(posedge clk) disable iff (rst) reg_write_en |-> out_valid)
        else begin
            fail_count++;
            $error("reg_write_en outside EXEC2");
        end

    // a stalled EXEC2 freezes every output
    assert property (@(posedge clk) disable iff (rst)
        stall && out_valid |=> out_valid && $stable(instr_code) && $stable(dest_reg) &&
            $stable(shift_amount) && $stable(jump_target) && $stable(operand_a) &&
            $stable(operand_b) && $stable(reg_write_en))
        else begin
            fail_count++;
            $error("outputs changed during a stalled EXEC2");
        end

    assert property (@(posedge clk) $fell(rst) |-> phase == mips_pkg::FETCH)
        else begin
            fail_count++;
            $error("phase not FETCH after reset release");
        end

endmodule

/* dv/decode_stage_tb.sv */
// Decode stage testbench
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int MAX_VEC  = 32;
    localparam int COLS     = 7;    // instr, wb_data, code, dest, op_a, op_b, write enable
    localparam int WAIT_MAX = 20;   // cycles allowed for any handshake

    logic                clk;
    logic                rst;
    logic                stall;
    logic [31:0]         instr;
    logic [31:0]         wb_data;
    mips_pkg::instcode_t instr_code;
    logic [4:0]          dest_reg;
    logic [4:0]          shift_amount;
    logic [25:0]         jump_target;
    logic [31:0]         operand_a;
    logic [31:0]         operand_b;
    logic                reg_write_en;
    logic                out_valid;
    logic                fetch;

    logic [31:0] vec_mem [MAX_VEC*COLS];
    int          num_vec;
    int          cur_vec;
    int          checks;
    int          errors;
    int          assert_fails;
    bit          timed_out;

    tb_clock clock_gen (.clk(clk));

    decode_stage decode_stage_inst (
        .clk(clk), .rst(rst), .stall(stall), .instr(instr), .wb_data(wb_data),
        .instr_code(instr_code), .dest_reg(dest_reg), .shift_amount(shift_amount),
        .jump_target(jump_target), .operand_a(operand_a), .operand_b(operand_b),
        .reg_write_en(reg_write_en), .out_valid(out_valid), .fetch(fetch)
    );

    bind decode_stage decode_stage_asserts asserts_inst (
        .clk(clk), .rst(rst), .stall(stall), .phase(phase), .instr_code(instr_code),
        .dest_reg(dest_reg), .shift_amount(shift_amount), .jump_target(jump_target),
        .operand_a(operand_a), .operand_b(operand_b), .reg_write_en(reg_write_en),
        .out_valid(out_valid)
    );

    task automatic check_code(input string name, input mips_pkg::instcode_t exp,
                              input mips_pkg::instcode_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t vec %0d %s: expected %s(%0d), got %s(%0d)", $time, cur_vec,
                     name, exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic check_reg_idx(input string name, input logic [4:0] exp, input logic [4:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t vec %0d %s: expected %0d, got %0d", $time, cur_vec, name, exp, act);
        end
    endtask

    task automatic check_target(input string name, input logic [25:0] exp,
                                input logic [25:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t vec %0d %s: expected %h, got %h", $time, cur_vec, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t vec %0d %s: expected %h, got %h", $time, cur_vec, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t vec %0d %s: expected %b, got %b", $time, cur_vec, name, exp, act);
        end
    endtask

    // shift amount exists only in the SPECIAL format
    function automatic logic [4:0] expected_shamt(input logic [31:0] word);
        return (word[31:26] == 6'h00) ? word[10:6] : 5'd0;
    endfunction

    function automatic logic [25:0] expected_target(input logic [31:0] word);
        return (word[31:26] == 6'h02 || word[31:26] == 6'h03) ? word[25:0] : 26'd0;
    endfunction

    task automatic load_vectors();
        for (int i = 0; i < MAX_VEC*COLS; i++) begin
            vec_mem[i] = 32'hdead_0000 | 32'(i);   // stays above 1 where the file has no line
        end
        $readmemh("dv/decode_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec*COLS + 6] <= 32'd1) begin
            num_vec++;
        end
    endtask

    task automatic wait_for_fetch();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!fetch && cycles < WAIT_MAX);
        if (!fetch) begin
            timed_out = 1'b1;
            $display("timeout at %0t: fetch phase never came", $time);
        end
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!out_valid && cycles < WAIT_MAX);
        if (!out_valid) begin
            timed_out = 1'b1;
            $display("timeout at %0t: out_valid never rose", $time);
        end
    endtask

    task automatic check_outputs(input int i);
        logic [31:0] word;
        word = vec_mem[i*COLS];
        check_bit("out_valid", 1'b1, out_valid);
        check_bit("fetch", 1'b0, fetch);
        check_code("instr_code", mips_pkg::instcode_t'(vec_mem[i*COLS + 2][6:0]), instr_code);
        check_reg_idx("dest_reg", vec_mem[i*COLS + 3][4:0], dest_reg);
        check_reg_idx("shift_amount", expected_shamt(word), shift_amount);
        check_target("jump_target", expected_target(word), jump_target);
        check_word("operand_a", vec_mem[i*COLS + 4], operand_a);
        check_word("operand_b", vec_mem[i*COLS + 5], operand_b);
        check_bit("reg_write_en", vec_mem[i*COLS + 6][0], reg_write_en);
    endtask

    task automatic run_vector(input int i);
        int n_stall;
        n_stall = int'($urandom % 3);   // extra EXEC2 cycles
        wait_for_fetch();
        if (timed_out) begin
            return;
        end
        @(posedge clk);   // edge that ends FETCH
        instr   <= vec_mem[i*COLS];
        wb_data <= vec_mem[i*COLS + 1];
        @(posedge clk);   // end of EXEC1, where the stall for EXEC2 is set up
        stall <= (n_stall > 0);
        wait_for_valid();
        if (timed_out) begin
            return;
        end
        check_outputs(i);
        for (int k = 1; k <= n_stall; k++) begin
            @(posedge clk);
            if (k == n_stall) begin
                stall <= 1'b0;
            end
            @(negedge clk);
            check_outputs(i);   // outputs held while the write waits
        end
    endtask

    initial begin
        void'($urandom(32'h9a1f_2993));
        checks    = 0;
        errors    = 0;
        cur_vec   = 0;
        timed_out = 1'b0;
        rst     <= 1'b1;
        stall   <= 1'b0;
        instr   <= 32'd0;
        wb_data <= 32'd0;
        load_vectors();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_vec && !timed_out; i++) begin
            cur_vec = i;
            run_vector(i);
        end
        if (num_vec == 0) begin
            $display("no vectors found in dv/decode_vectors.txt");
        end
        assert_fails = decode_stage_inst.asserts_inst.fail_count;
        $display("vectors %0d, checks %0d, errors %0d, assertion failures %0d, timeout %0d",
                 num_vec, checks, errors, assert_fails, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out && num_vec > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dv/decode_vectors.txt */
// instr wb_data instr_code dest_reg operand_a operand_b reg_write_en
// registers clear at reset, each line sees the writes of the lines above it
3c051234 12340000 2e 05 00000000 12340000 1 // lui $5, 0x1234
34068001 00008001 10 06 00000000 00008001 1 // ori $6, $0, 0x8001
00a63820 12348001 01 07 12340000 00008001 1 // add $7, $5, $6
20e8fffc 12347ffd 02 08 12348001 fffffffc 1 // addi $8, $7, -4
01054823 00007ffd 1b 09 12347ffd 12340000 1 // subu $9, $8, $5
00065100 00080010 11 0a 00000000 00008001 1 // sll $10, $6, 4
00e00008 deadbeef 29 00 12348001 00000000 0 // jr $7
0c123456 00400008 27 1f 00000000 00000000 1 // jal 0x0123456
05310010 00400010 20 1f 00007ffd 00000000 1 // bgezal $9, 0x10
0bfffffc cafef00d 26 00 00000000 00000000 0 // j 0x3fffffc
24a00100 ffffffff 03 00 12340000 00000100 1 // addiu $0, $5, 0x100
00055820 12340000 01 0b 00000000 12340000 1 // add $11, $0, $5
10a60008 11111111 1e 06 12340000 00008001 0 // beq $5, $6, 8
afe9fff8 22222222 34 09 00400010 fffffff8 0 // sw $9, -8($31)
03e86020 00000000 01 0c 00400010 12347ffd 1 // add $12, $31, $8

/* dv/tb_clock.sv */
// Testbench clock source
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

endmodule

/* rtl/decode_if.sv */
// Decoded instruction fields
`timescale 1ns/1ps

interface decode_if;

    mips_pkg::instcode_t code;
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [4:0]  dest_idx;
    logic [4:0]  shamt;
    logic [31:0] imm;        // already extended to 32 bits
    logic [25:0] target;     // J and JAL only
    logic        uses_imm;   // operand b comes from imm
    logic        write_en;   // EXEC2 only

    modport dec (output code, rs_idx, rt_idx, dest_idx, shamt, imm, target,
                 uses_imm, write_en);

    modport rf (input rs_idx, rt_idx);

    modport sel (input code, rs_idx, rt_idx, dest_idx, shamt, imm, target,
                 uses_imm, write_en);

endinterface

/* rtl/decode_stage.sv */
// MIPS-I decode stage
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic [31:0]         instr,
    input  logic [31:0]         wb_data,
    output mips_pkg::instcode_t instr_code,
    output logic [4:0]          dest_reg,
    output logic [4:0]          shift_amount,
    output logic [25:0]         jump_target,
    output logic [31:0]         operand_a,
    output logic [31:0]         operand_b,
    output logic                reg_write_en,
    output logic                out_valid,
    output logic                fetch
);

    mips_pkg::phase_t phase;
    logic [31:0]      rs_data;
    logic [31:0]      rt_data;
    logic             wr_en;
    logic [4:0]       wr_idx;
    logic [31:0]      wr_data;

    decode_if dif ();

    phase_ctrl phase_ctrl_inst (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .phase (phase)
    );

    ir_decode ir_decode_inst (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .phase (phase),
        .instr (instr),
        .d     (dif)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .d       (dif),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    operand_select operand_select_inst (
        .d            (dif),
        .stall        (stall),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .wb_data      (wb_data),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .dest_reg     (dest_reg),
        .shift_amount (shift_amount),
        .jump_target  (jump_target),
        .instr_code   (instr_code),
        .reg_write_en (reg_write_en),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data)
    );

    assign out_valid = (phase == mips_pkg::EXEC2);
    assign fetch     = (phase == mips_pkg::FETCH);

endmodule

/* rtl/ir_decode.sv */
// Instruction register and decoder
`timescale 1ns/1ps

module ir_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  mips_pkg::phase_t phase,
    input  logic [31:0]      instr,
    decode_if.dec            d
);

    logic [31:0] ir;
    logic [31:0] word;
    logic        active;
    logic        r_type;
    logic        j_type;
    logic        i_type;
    logic        is_branch;
    logic        r_write;
    logic        i_write;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rt;
    mips_pkg::instcode_t code;

    // word is captured at the edge that ends EXEC1
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (phase == mips_pkg::EXEC1 && !stall) begin
            ir <= instr;
        end
    end

    assign active = (phase == mips_pkg::EXEC1) || (phase == mips_pkg::EXEC2);
    assign word   = (phase == mips_pkg::EXEC1) ? instr :
                    (phase == mips_pkg::EXEC2) ? ir : 32'd0;

    assign opcode = word[31:26];
    assign funct  = word[5:0];
    assign rt     = word[20:16];

    assign r_type    = active && (opcode == mips_pkg::OP_SPECIAL);
    assign j_type    = active && (opcode == mips_pkg::OP_J || opcode == mips_pkg::OP_JAL);
    assign i_type    = active && !r_type && !j_type;
    assign is_branch = (opcode == mips_pkg::OP_REGIMM) || (opcode == mips_pkg::OP_BEQ) ||
                       (opcode == mips_pkg::OP_BNE) || (opcode == mips_pkg::OP_BLEZ) ||
                       (opcode == mips_pkg::OP_BGTZ);

    always_comb begin
        code = mips_pkg::NONE;
        if (active) begin
            case (opcode)
                mips_pkg::OP_SPECIAL: begin
                    case (funct)
                        mips_pkg::FN_SLL:   code = mips_pkg::SLL;
                        mips_pkg::FN_SRL:   code = mips_pkg::SRL;
                        mips_pkg::FN_SRA:   code = mips_pkg::SRA;
                        mips_pkg::FN_SLLV:  code = mips_pkg::SLLV;
                        mips_pkg::FN_SRLV:  code = mips_pkg::SRLV;
                        mips_pkg::FN_SRAV:  code = mips_pkg::SRAV;
                        mips_pkg::FN_JR:    code = mips_pkg::JR;
                        mips_pkg::FN_JALR:  code = mips_pkg::JALR;
                        mips_pkg::FN_MFHI:  code = mips_pkg::MFHI;
                        mips_pkg::FN_MTHI:  code = mips_pkg::MTHI;
                        mips_pkg::FN_MFLO:  code = mips_pkg::MFLO;
                        mips_pkg::FN_MTLO:  code = mips_pkg::MTLO;
                        mips_pkg::FN_MULT:  code = mips_pkg::MULT;
                        mips_pkg::FN_MULTU: code = mips_pkg::MULTU;
                        mips_pkg::FN_DIV:   code = mips_pkg::DIV;
                        mips_pkg::FN_DIVU:  code = mips_pkg::DIVU;
                        mips_pkg::FN_ADD:   code = mips_pkg::ADD;
                        mips_pkg::FN_ADDU:  code = mips_pkg::ADDU;
                        mips_pkg::FN_SUBU:  code = mips_pkg::SUBU;
                        mips_pkg::FN_AND:   code = mips_pkg::AND;
                        mips_pkg::FN_OR:    code = mips_pkg::OR;
                        mips_pkg::FN_XOR:   code = mips_pkg::XOR;
                        mips_pkg::FN_SLT:   code = mips_pkg::SLT;
                        mips_pkg::FN_SLTU:  code = mips_pkg::SLTU;
                        default:            code = mips_pkg::NONE;
                    endcase
                end
                mips_pkg::OP_REGIMM: begin   // branch kind sits in rt
                    case (rt)
                        mips_pkg::RT_BLTZ:   code = mips_pkg::BLTZ;
                        mips_pkg::RT_BGEZ:   code = mips_pkg::BGEZ;
                        mips_pkg::RT_BLTZAL: code = mips_pkg::BLTZAL;
                        mips_pkg::RT_BGEZAL: code = mips_pkg::BGEZAL;
                        default:             code = mips_pkg::NONE;
                    endcase
                end
                mips_pkg::OP_J:     code = mips_pkg::J;
                mips_pkg::OP_JAL:   code = mips_pkg::JAL;
                mips_pkg::OP_BEQ:   code = mips_pkg::BEQ;
                mips_pkg::OP_BNE:   code = mips_pkg::BNE;
                mips_pkg::OP_BLEZ:  code = mips_pkg::BLEZ;
                mips_pkg::OP_BGTZ:  code = mips_pkg::BGTZ;
                mips_pkg::OP_ADDI:  code = mips_pkg::ADDI;
                mips_pkg::OP_ADDIU: code = mips_pkg::ADDIU;
                mips_pkg::OP_SLTI:  code = mips_pkg::SLTI;
                mips_pkg::OP_SLTIU: code = mips_pkg::SLTIU;
                mips_pkg::OP_ANDI:  code = mips_pkg::ANDI;
                mips_pkg::OP_ORI:   code = mips_pkg::ORI;
                mips_pkg::OP_XORI:  code = mips_pkg::XORI;
                mips_pkg::OP_LUI:   code = mips_pkg::LUI;
                mips_pkg::OP_LB:    code = mips_pkg::LB;
                mips_pkg::OP_LH:    code = mips_pkg::LH;
                mips_pkg::OP_LWL:   code = mips_pkg::LWL;
                mips_pkg::OP_LW:    code = mips_pkg::LW;
                mips_pkg::OP_LBU:   code = mips_pkg::LBU;
                mips_pkg::OP_LHU:   code = mips_pkg::LHU;
                mips_pkg::OP_LWR:   code = mips_pkg::LWR;
                mips_pkg::OP_SB:    code = mips_pkg::SB;
                mips_pkg::OP_SH:    code = mips_pkg::SH;
                mips_pkg::OP_SW:    code = mips_pkg::SW;
                default:            code = mips_pkg::NONE;
            endcase
        end
    end

    // destination and immediate depend on the instruction format
    always_comb begin
        d.dest_idx = 5'd0;
        d.imm      = 32'd0;
        if (r_type) begin
            d.dest_idx = word[15:11];   // rd
        end else if (j_type) begin
            d.dest_idx = (code == mips_pkg::JAL) ? mips_pkg::LINK_REG : 5'd0;
        end else if (i_type) begin
            if (code == mips_pkg::BGEZAL || code == mips_pkg::BLTZAL) begin
                d.dest_idx = mips_pkg::LINK_REG;
            end else begin
                d.dest_idx = rt;
            end
            case (code)
                mips_pkg::ANDI, mips_pkg::ORI, mips_pkg::XORI: d.imm = {16'd0, word[15:0]};
                mips_pkg::LUI: d.imm = {word[15:0], 16'd0};
                default:       d.imm = {{16{word[15]}}, word[15:0]};
            endcase
        end
    end

    // I and J formats that produce a register result
    always_comb begin
        case (code)
            mips_pkg::ADDI, mips_pkg::ADDIU, mips_pkg::SLTI, mips_pkg::SLTIU,
            mips_pkg::ANDI, mips_pkg::ORI, mips_pkg::XORI, mips_pkg::LUI,
            mips_pkg::LB, mips_pkg::LBU, mips_pkg::LH, mips_pkg::LHU,
            mips_pkg::LW, mips_pkg::LWL, mips_pkg::LWR,
            mips_pkg::JAL, mips_pkg::BGEZAL, mips_pkg::BLTZAL: i_write = 1'b1;
            default:                                           i_write = 1'b0;
        endcase
    end

    assign r_write = r_type && (code != mips_pkg::NONE) && (code != mips_pkg::MTHI) &&
                     (code != mips_pkg::MTLO) && (code != mips_pkg::JR);

    assign d.code     = code;
    assign d.rs_idx   = j_type ? 5'd0 : word[25:21];
    assign d.rt_idx   = j_type ? 5'd0 : rt;
    assign d.shamt    = r_type ? word[10:6] : 5'd0;
    assign d.target   = j_type ? word[25:0] : 26'd0;
    assign d.uses_imm = i_type && !is_branch;
    assign d.write_en = (phase == mips_pkg::EXEC2) && (r_write || i_write);

endmodule

/* rtl/mips_pkg.sv */
// MIPS-I decode definitions
package mips_pkg;

    typedef enum logic [1:0] {
        FETCH,
        EXEC1,
        EXEC2
    } phase_t;

    // numbering follows the instruction table, 0 marks an unknown word
    typedef enum logic [6:0] {
        NONE = 7'd0,
        ADD, ADDI, ADDIU, ADDU, AND, ANDI, DIV, DIVU,       // 1 to 8
        MFHI, MFLO, MTHI, MTLO, MULT, MULTU, OR, ORI,       // 9 to 16
        SLL, SLLV, SLT, SLTI, SLTIU, SLTU, SRA, SRAV,       // 17 to 24
        SRL, SRLV, SUBU, XOR, XORI,                         // 25 to 29
        BEQ, BGEZ, BGEZAL, BGTZ, BLEZ, BLTZ, BLTZAL, BNE,   // 30 to 37
        J, JAL, JALR, JR,                                   // 38 to 41
        LB, LBU, LH, LHU, LUI, LW, LWL, LWR,                // 42 to 49
        SB, SH, SW                                          // 50 to 52
    } instcode_t;

    // primary opcodes, bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02,
                           OP_JAL     = 6'h03, OP_BEQ    = 6'h04, OP_BNE   = 6'h05,
                           OP_BLEZ    = 6'h06, OP_BGTZ   = 6'h07, OP_ADDI  = 6'h08,
                           OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a, OP_SLTIU = 6'h0b,
                           OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e,
                           OP_LUI     = 6'h0f, OP_LB     = 6'h20, OP_LH    = 6'h21,
                           OP_LWL     = 6'h22, OP_LW     = 6'h23, OP_LBU   = 6'h24,
                           OP_LHU     = 6'h25, OP_LWR    = 6'h26, OP_SB    = 6'h28,
                           OP_SH      = 6'h29, OP_SW     = 6'h2b;

    // SPECIAL funct field, bits 5:0
    localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA  = 6'h03,
                           FN_SLLV = 6'h04, FN_SRLV  = 6'h06, FN_SRAV = 6'h07,
                           FN_JR   = 6'h08, FN_JALR  = 6'h09, FN_MFHI = 6'h10,
                           FN_MTHI = 6'h11, FN_MFLO  = 6'h12, FN_MTLO = 6'h13,
                           FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV  = 6'h1a,
                           FN_DIVU = 6'h1b, FN_ADD   = 6'h20, FN_ADDU = 6'h21,
                           FN_SUBU = 6'h23, FN_AND   = 6'h24, FN_OR   = 6'h25,
                           FN_XOR  = 6'h26, FN_SLT   = 6'h2a, FN_SLTU = 6'h2b;

    // REGIMM branch selects in the rt field
    localparam logic [4:0] RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10,
                           RT_BGEZAL = 5'h11;

    localparam logic [4:0] LINK_REG = 5'd31;   // $ra

endpackage

/* rtl/operand_select.sv */
// Operand and write port selection
`timescale 1ns/1ps

module operand_select (
    decode_if.sel               d,
    input  logic                stall,
    input  logic [31:0]         rs_data,
    input  logic [31:0]         rt_data,
    input  logic [31:0]         wb_data,
    output logic [31:0]         operand_a,
    output logic [31:0]         operand_b,
    output logic [4:0]          dest_reg,
    output logic [4:0]          shift_amount,
    output logic [25:0]         jump_target,
    output mips_pkg::instcode_t instr_code,
    output logic                reg_write_en,
    output logic                wr_en,
    output logic [4:0]          wr_idx,
    output logic [31:0]         wr_data
);

    assign operand_a    = rs_data;
    assign operand_b    = d.uses_imm ? d.imm : rt_data;   // branches compare against rt
    assign dest_reg     = d.dest_idx;
    assign shift_amount = d.shamt;
    assign jump_target  = d.target;
    assign instr_code   = d.code;
    assign reg_write_en = d.write_en;

    // a stalled EXEC2 defers the write, and $zero never takes one
    assign wr_en   = d.write_en && !stall && (d.dest_idx != 5'd0);
    assign wr_idx  = d.dest_idx;
    assign wr_data = wb_data;

endmodule

/* rtl/phase_ctrl.sv */
// Fetch and execute phase sequencer
`timescale 1ns/1ps

module phase_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    output mips_pkg::phase_t phase
);

    mips_pkg::phase_t phase_next;

    always_comb begin
        case (phase)
            mips_pkg::FETCH: phase_next = mips_pkg::EXEC1;
            mips_pkg::EXEC1: phase_next = mips_pkg::EXEC2;
            default:         phase_next = mips_pkg::FETCH;
        endcase
    end

    // one instruction every three cycles, stall holds the current phase
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= mips_pkg::FETCH;
        end else if (!stall) begin
            phase <= phase_next;
        end
    end

endmodule

/* rtl/reg_file.sv */
// General purpose register file
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [4:0]  wr_idx,
    input  logic [31:0] wr_data,
    decode_if.rf        d,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // entry 0 keeps its reset value since the write port never selects it
    assign rs_data = regs[d.rs_idx];
    assign rt_data = regs[d.rt_idx];

endmodule

/* sim.f */
rtl/mips_pkg.sv
rtl/decode_if.sv
rtl/phase_ctrl.sv
rtl/ir_decode.sv
rtl/reg_file.sv
rtl/operand_select.sv
rtl/decode_stage.sv
dv/tb_clock.sv
dv/decode_stage_asserts.sv
dv/decode_stage_tb.sv
